//--- design/cam_bist_pkg.sv
/*
 * Shared request, control and state types for the CAM self-test wrapper.
 * Imported by every design block that carries CAM traffic or BIST control.
 */
package cam_bist_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------

   // Widest data word any instance may use
   localparam int MAX_DATA_WIDTH = 32;
   // Entry index field width
   localparam int ADDR_WIDTH = 8;

   // ------------------------------------------------------------
   // Background patterns
   // ------------------------------------------------------------

   // All zeros
   localparam logic [MAX_DATA_WIDTH-1:0] BG_SOLID_WORD = 32'h0000_0000;
   // Bit 0 low, bit 1 high, and so on upward
   localparam logic [MAX_DATA_WIDTH-1:0] BG_CHECKER_WORD = 32'hAAAA_AAAA;

   // ------------------------------------------------------------
   // Request and control bundles
   // ------------------------------------------------------------

   // Write request, data used from the low end
   typedef struct packed {
      logic                      en;
      logic [ADDR_WIDTH-1:0]     addr;
      logic [MAX_DATA_WIDTH-1:0] data;
   } cam_wr_req_t;

   // Compare request
   typedef struct packed {
      logic                      en;
      logic [MAX_DATA_WIDTH-1:0] data;
   } cam_cm_req_t;

   // Controls from the sequencer to the input handler and analyzer
   typedef struct packed {
      logic cm_mode;
      logic rotate_mask;
      logic cd_mask_enable;
      logic data_inv;
      logic expect_hit;
   } bist_ctrl_t;

   // March states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE,
      ST_CM_ALL,
      ST_CM_WALK,
      ST_DRAIN,
      ST_DONE
   } bist_state_e;

   // Background select
   typedef enum logic {
      BG_SOLID,
      BG_CHECKER
   } bist_bg_e;

endpackage

//--- design/cam_bist_sequencer.sv
/*
 * March controller for the CAM self-test. Writes a background, runs one full
 * compare and a walking-mask compare series, over four background passes.
 */
`timescale 1ns/1ps

module cam_bist_sequencer
   import cam_bist_pkg::*;
#(
   parameter int DATA_WIDTH = 8,
   parameter int ENTRIES    = 8
) (
   input  logic        bist_clk,
   input  logic        rst_b,
   input  logic        bist_start,
   output bist_ctrl_t  bist_ctrl,
   output cam_wr_req_t bist_wr,
   output logic        bist_cm_en,
   output bist_bg_e    bist_bg,
   output logic        bist_busy
);

   // ------------------------------------------------------------
   // Counter widths and end values
   // ------------------------------------------------------------

   localparam int EW = $clog2(ENTRIES);
   localparam int WW = $clog2(DATA_WIDTH);

   localparam logic [EW-1:0] LAST_ENTRY = EW'(ENTRIES - 1);
   localparam logic [WW-1:0] LAST_STEP  = WW'(DATA_WIDTH - 1);

   bist_state_e               state;
   // Pass order: bit 1 picks checker, bit 0 picks inversion
   logic [1:0]                pass_cnt;
   logic [EW-1:0]             entry_cnt;
   logic [WW-1:0]             walk_cnt;
   logic [MAX_DATA_WIDTH-1:0] bg_word;

   // ------------------------------------------------------------
   // State and counters
   // ------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state     <= ST_IDLE;
         pass_cnt  <= '0;
         entry_cnt <= '0;
         walk_cnt  <= '0;
      end else begin
         case (state)
            // Start only from rest, a start while busy is dropped
            ST_IDLE, ST_DONE: begin
               if (bist_start) begin
                  state     <= ST_WRITE;
                  pass_cnt  <= '0;
                  entry_cnt <= '0;
                  walk_cnt  <= '0;
               end
            end
            // One entry per cycle
            ST_WRITE: begin
               if (entry_cnt == LAST_ENTRY) begin
                  entry_cnt <= '0;
                  state     <= ST_CM_ALL;
               end else begin
                  entry_cnt <= entry_cnt + 1'b1;
               end
            end
            // Single unmasked compare
            ST_CM_ALL: begin
               walk_cnt <= '0;
               state    <= ST_CM_WALK;
            end
            // One masked compare per data bit
            ST_CM_WALK: begin
               if (walk_cnt == LAST_STEP) begin
                  walk_cnt <= '0;
                  if (pass_cnt == 2'd3) begin
                     state <= ST_DRAIN;
                  end else begin
                     pass_cnt <= pass_cnt + 1'b1;
                     state    <= ST_WRITE;
                  end
               end else begin
                  walk_cnt <= walk_cnt + 1'b1;
               end
            end
            // Let the last match vector land
            ST_DRAIN: begin
               state <= ST_DONE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // ------------------------------------------------------------
   // Decoded outputs
   // ------------------------------------------------------------

   always_comb begin
      bist_bg = pass_cnt[1] ? BG_CHECKER : BG_SOLID;
      bg_word = pass_cnt[1] ? BG_CHECKER_WORD : BG_SOLID_WORD;

      bist_busy = state inside {ST_WRITE, ST_CM_ALL, ST_CM_WALK, ST_DRAIN};

      // Array belongs to BIST from first write to last compare
      bist_ctrl.cm_mode        = state inside {ST_WRITE, ST_CM_ALL, ST_CM_WALK};
      // Mask steps once with each walking compare
      bist_ctrl.rotate_mask    = (state == ST_CM_WALK);
      bist_ctrl.cd_mask_enable = (state == ST_CM_WALK);
      bist_ctrl.data_inv       = pass_cnt[0] && bist_ctrl.cm_mode;
      bist_ctrl.expect_hit     = (state == ST_CM_ALL);

      // Background goes out raw, inversion happens downstream
      bist_wr.en   = (state == ST_WRITE);
      bist_wr.addr = ADDR_WIDTH'(entry_cnt);
      bist_wr.data = bg_word;

      bist_cm_en = state inside {ST_CM_ALL, ST_CM_WALK};
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------

   // Mask only moves in the walk that follows the full compare
   a_rotate_in_walk: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bist_ctrl.rotate_mask |-> $past(bist_ctrl.expect_hit) || $past(bist_ctrl.rotate_mask));

endmodule

//--- design/cam_bist_inhandler.sv
/*
 * BIST input stage in front of the CAM. Holds the walking mask, inverts data,
 * builds compare data and picks BIST or functional traffic.
 */
`timescale 1ns/1ps

module cam_bist_inhandler
   import cam_bist_pkg::*;
#(
   parameter int DATA_WIDTH = 8
) (
   input  logic        bist_clk,
   input  logic        rst_b,
   input  logic        bist_start,
   input  bist_ctrl_t  bist_ctrl,
   input  cam_wr_req_t bist_wr,
   input  logic        bist_cm_en,
   input  bist_bg_e    bist_bg,
   input  cam_wr_req_t func_wr,
   input  cam_cm_req_t func_cm,
   output cam_wr_req_t arr_wr,
   output cam_cm_req_t arr_cm
);

   logic [DATA_WIDTH-1:0] mask;
   logic [DATA_WIDTH-1:0] bg_data;
   logic [DATA_WIDTH-1:0] inv_vec;
   logic [DATA_WIDTH-1:0] bist_wr_data;
   logic [DATA_WIDTH-1:0] bist_cm_data;

   // ------------------------------------------------------------
   // Rotating one-hot mask
   // ------------------------------------------------------------

   // Rotates left, top bit wraps to bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= DATA_WIDTH'(1);
      end else if (bist_start && !bist_ctrl.cm_mode) begin
         mask <= DATA_WIDTH'(1);
      end else if (bist_ctrl.rotate_mask) begin
         mask <= {mask[DATA_WIDTH-2:0], mask[DATA_WIDTH-1]};
      end
   end

   // ------------------------------------------------------------
   // Write and compare data
   // ------------------------------------------------------------

   assign bg_data = (bist_bg == BG_CHECKER) ? BG_CHECKER_WORD[DATA_WIDTH-1:0]
                                            : BG_SOLID_WORD[DATA_WIDTH-1:0];

   assign inv_vec = {DATA_WIDTH{bist_ctrl.data_inv}};

   // Inverted passes store the complement
   assign bist_wr_data = bist_wr.data[DATA_WIDTH-1:0] ^ inv_vec;

   // Masked bit is flipped so no entry should match
   assign bist_cm_data = bg_data ^ inv_vec ^ (mask & {DATA_WIDTH{bist_ctrl.cd_mask_enable}});

   // ------------------------------------------------------------
   // Traffic select
   // ------------------------------------------------------------

   always_comb begin
      if (bist_ctrl.cm_mode) begin
         arr_wr.en   = bist_wr.en;
         arr_wr.addr = bist_wr.addr;
         arr_wr.data = MAX_DATA_WIDTH'(bist_wr_data);
         arr_cm.en   = bist_cm_en;
         arr_cm.data = MAX_DATA_WIDTH'(bist_cm_data);
      end else begin
         // Functional path untouched
         arr_wr = func_wr;
         arr_cm = func_cm;
      end
   end

   // Exactly one bit flipped per walking step
   a_mask_onehot: assert property (@(posedge bist_clk) disable iff (!rst_b)
      $onehot(mask));

endmodule

//--- design/cam_array.sv
/*
 * Behavioral binary CAM with one write port. A compare returns a match
 * vector one cycle later, with a valid strobe.
 */
`timescale 1ns/1ps

module cam_array
   import cam_bist_pkg::*;
#(
   parameter int DATA_WIDTH = 8,
   parameter int ENTRIES    = 8
) (
   input  logic               bist_clk,
   input  logic               rst_b,
   input  cam_wr_req_t        arr_wr,
   input  cam_cm_req_t        arr_cm,
   output logic [ENTRIES-1:0] hit,
   output logic               hit_valid
);

   localparam int EW = $clog2(ENTRIES);

   // Entry storage
   logic [DATA_WIDTH-1:0] mem [ENTRIES];
   // Entry has been written since reset
   logic [ENTRIES-1:0]    entry_valid;
   logic [DATA_WIDTH-1:0] cm_data;
   logic [ENTRIES-1:0]    hit_next;

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (arr_wr.en) begin
         mem[arr_wr.addr[EW-1:0]] <= arr_wr.data[DATA_WIDTH-1:0];
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         entry_valid <= '0;
      end else if (arr_wr.en) begin
         entry_valid[arr_wr.addr[EW-1:0]] <= 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Compare
   // ------------------------------------------------------------

   assign cm_data = arr_cm.data[DATA_WIDTH-1:0];

   // Parallel match across all entries
   always_comb begin
      for (int i = 0; i < ENTRIES; i++) begin
         hit_next[i] = entry_valid[i] && (mem[i] == cm_data);
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         hit_valid <= 1'b0;
      end else begin
         hit_valid <= arr_cm.en;
      end
   end

   // Vector holds until the next compare
   always_ff @(posedge bist_clk) begin
      if (arr_cm.en) begin
         hit <= hit_next;
      end
   end

   // Writers upstream must stay inside the array
   a_wr_addr_range: assert property (@(posedge bist_clk) disable iff (!rst_b)
      arr_wr.en |-> arr_wr.addr < ADDR_WIDTH'(ENTRIES));

endmodule

//--- design/cam_bist_analyzer.sv
/*
 * BIST response checker. Compares each BIST match vector against all-hit or
 * no-hit and keeps the sticky fail flag, the fail count and first failing entry.
 */
`timescale 1ns/1ps

module cam_bist_analyzer
   import cam_bist_pkg::*;
#(
   parameter int ENTRIES = 8
) (
   input  logic               bist_clk,
   input  logic               rst_b,
   input  logic               bist_start,
   input  logic               bist_busy,
   input  bist_ctrl_t         bist_ctrl,
   input  logic [ENTRIES-1:0] hit,
   input  logic               hit_valid,
   output logic               bist_done,
   output logic               bist_fail,
   output logic [7:0]         fail_count,
   output logic [7:0]         first_fail_entry
);

   // Expectation aligned with the array output
   logic               cm_mode_q;
   logic               expect_hit_q;
   // Falling edge of busy marks the end of a run
   logic               busy_q;
   logic [ENTRIES-1:0] exp_vec;
   logic [ENTRIES-1:0] miss_vec;
   logic               miss;
   logic [7:0]         low_idx;

   // ------------------------------------------------------------
   // Mismatch detect
   // ------------------------------------------------------------

   assign exp_vec  = {ENTRIES{expect_hit_q}};
   assign miss_vec = hit ^ exp_vec;
   assign miss     = hit_valid && cm_mode_q && (|miss_vec);

   // Lowest failing index wins
   always_comb begin
      low_idx = '0;
      for (int i = ENTRIES - 1; i >= 0; i--) begin
         if (miss_vec[i]) begin
            low_idx = 8'(i);
         end
      end
   end

   // ------------------------------------------------------------
   // Status registers
   // ------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         cm_mode_q        <= 1'b0;
         expect_hit_q     <= 1'b0;
         busy_q           <= 1'b0;
         bist_done        <= 1'b0;
         bist_fail        <= 1'b0;
         fail_count       <= '0;
         first_fail_entry <= '0;
      end else begin
         cm_mode_q    <= bist_ctrl.cm_mode;
         expect_hit_q <= bist_ctrl.expect_hit;
         busy_q       <= bist_busy;
         // New run clears status, same condition the sequencer accepts
         if (bist_start && !bist_busy) begin
            bist_done        <= 1'b0;
            bist_fail        <= 1'b0;
            fail_count       <= '0;
            first_fail_entry <= '0;
         end else begin
            if (busy_q && !bist_busy) begin
               bist_done <= 1'b1;
            end
            if (miss) begin
               bist_fail <= 1'b1;
               // Saturate rather than wrap
               if (fail_count != 8'hFF) begin
                  fail_count <= fail_count + 1'b1;
               end
               if (!bist_fail) begin
                  first_fail_entry <= low_idx;
               end
            end
         end
      end
   end

   // Done only ever shows with the sequencer at rest
   a_done_idle: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bist_done |-> !bist_busy);

endmodule

//--- design/cam_bist_top.sv
/*
 * CAM with built-in self-test. Functional requests reach the array unless a
 * BIST run owns it; results come out as done, fail and failing entry.
 */
`timescale 1ns/1ps

module cam_bist_top
   import cam_bist_pkg::*;
#(
   parameter int DATA_WIDTH = 8,
   parameter int ENTRIES    = 8
) (
   input  logic               bist_clk,
   input  logic               rst_b,
   input  logic               bist_start,
   input  cam_wr_req_t        func_wr,
   input  cam_cm_req_t        func_cm,
   output logic [ENTRIES-1:0] hit,
   output logic               hit_valid,
   output logic               bist_done,
   output logic               bist_fail,
   output logic [7:0]         fail_count,
   output logic [7:0]         first_fail_entry
);

   // Sequencer outputs
   bist_ctrl_t  bist_ctrl;
   cam_wr_req_t bist_wr;
   logic        bist_cm_en;
   bist_bg_e    bist_bg;
   logic        bist_busy;
   // Array side of the input handler
   cam_wr_req_t arr_wr;
   cam_cm_req_t arr_cm;

   // ------------------------------------------------------------
   // BIST control and data path
   // ------------------------------------------------------------

   cam_bist_sequencer #(
      .DATA_WIDTH (DATA_WIDTH),
      .ENTRIES    (ENTRIES)
   ) u_seq (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .bist_start (bist_start),
      .bist_ctrl  (bist_ctrl),
      .bist_wr    (bist_wr),
      .bist_cm_en (bist_cm_en),
      .bist_bg    (bist_bg),
      .bist_busy  (bist_busy)
   );

   cam_bist_inhandler #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_inh (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .bist_start (bist_start),
      .bist_ctrl  (bist_ctrl),
      .bist_wr    (bist_wr),
      .bist_cm_en (bist_cm_en),
      .bist_bg    (bist_bg),
      .func_wr    (func_wr),
      .func_cm    (func_cm),
      .arr_wr     (arr_wr),
      .arr_cm     (arr_cm)
   );

   // ------------------------------------------------------------
   // Array and response check
   // ------------------------------------------------------------

   cam_array #(
      .DATA_WIDTH (DATA_WIDTH),
      .ENTRIES    (ENTRIES)
   ) u_cam (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .arr_wr    (arr_wr),
      .arr_cm    (arr_cm),
      .hit       (hit),
      .hit_valid (hit_valid)
   );

   cam_bist_analyzer #(
      .ENTRIES (ENTRIES)
   ) u_ana (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .bist_start       (bist_start),
      .bist_busy        (bist_busy),
      .bist_ctrl        (bist_ctrl),
      .hit              (hit),
      .hit_valid        (hit_valid),
      .bist_done        (bist_done),
      .bist_fail        (bist_fail),
      .fail_count       (fail_count),
      .first_fail_entry (first_fail_entry)
   );

endmodule

//--- verif/cam_bist_checker.sv
/*
 * Scoreboard for the CAM self-test testbench. Mirrors functional and BIST
 * writes into a reference model, checks hit vectors and each BIST result.
 */
`timescale 1ns/1ps

module cam_bist_checker
   import cam_bist_pkg::*;
#(
   parameter int DATA_WIDTH = 8,
   parameter int ENTRIES    = 8
) (
   input  logic               bist_clk,
   input  logic               rst_b,
   input  logic               bist_start,
   input  cam_wr_req_t        func_wr,
   input  cam_cm_req_t        func_cm,
   input  logic [ENTRIES-1:0] hit,
   input  logic               hit_valid,
   input  logic               bist_done,
   input  logic               bist_fail,
   input  logic [7:0]         fail_count,
   input  logic [7:0]         first_fail_entry,
   input  logic               exp_fail,
   input  logic [7:0]         exp_first,
   output int                 hit_checks,
   output int                 hit_errors,
   output int                 status_errors,
   output int                 runs_checked
);

   localparam int EW         = $clog2(ENTRIES);
   // Start edge to done, four passes plus drain
   localparam int RUN_CYCLES = 4 * (ENTRIES + 1 + DATA_WIDTH) + 2;

   // Reference entries
   logic [DATA_WIDTH-1:0] ref_data [ENTRIES];
   logic [ENTRIES-1:0]    ref_valid;
   // BIST run in progress, as seen from the ports
   logic                  running;
   int                    run_cyc;
   // Functional compare waiting for its vector
   logic                  cm_pend;
   logic [ENTRIES-1:0]    cm_exp;
   logic [DATA_WIDTH-1:0] cm_word;
   logic                  rst_q;

   // Last pass is checker inverted, so even bits end up high
   function automatic logic [DATA_WIDTH-1:0] final_word();
      logic [DATA_WIDTH-1:0] w;
      for (int i = 0; i < DATA_WIDTH; i++) begin
         w[i] = ((i % 2) == 0);
      end
      return w;
   endfunction

   // Valid entries whose data equals the compare word
   function automatic logic [ENTRIES-1:0] model_hits(input logic [DATA_WIDTH-1:0] d);
      logic [ENTRIES-1:0] v;
      for (int i = 0; i < ENTRIES; i++) begin
         v[i] = ref_valid[i] && (ref_data[i] == d);
      end
      return v;
   endfunction

   task automatic log_failure(input logic hit_path, input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      if (hit_path) begin
         hit_errors++;
      end else begin
         status_errors++;
      end
   endtask

   always @(posedge bist_clk) begin
      if (!rst_b) begin
         ref_valid     <= '0;
         running       <= 1'b0;
         run_cyc       <= 0;
         cm_pend       <= 1'b0;
         rst_q         <= 1'b1;
         hit_checks    = 0;
         hit_errors    = 0;
         status_errors = 0;
         runs_checked  = 0;
      end else begin
         rst_q <= 1'b0;
         // First edge out of reset
         if (rst_q && (hit_valid || bist_done || bist_fail || fail_count != 8'd0
                       || first_fail_entry != 8'd0)) begin
            log_failure(1'b0, "status outputs not clear after reset");
         end

         // ------------------------------------------------------------
         // Functional compares
         // ------------------------------------------------------------
         if (cm_pend) begin
            hit_checks++;
            if (!hit_valid) begin
               $display("No hit_valid one cycle after the compare of %h at %0t", cm_word, $time);
               hit_errors++;
            end else if (hit != cm_exp) begin
               log_failure(1'b1, $sformatf("hit %b for data %h, expected %b",
                                           hit, cm_word, cm_exp));
            end
         end
         cm_pend <= func_cm.en && !running;
         if (func_cm.en && !running) begin
            cm_exp  <= model_hits(func_cm.data[DATA_WIDTH-1:0]);
            cm_word <= func_cm.data[DATA_WIDTH-1:0];
         end
         // Writes are dropped while BIST owns the array
         if (func_wr.en && !running) begin
            ref_data[func_wr.addr[EW-1:0]]  <= func_wr.data[DATA_WIDTH-1:0];
            ref_valid[func_wr.addr[EW-1:0]] <= 1'b1;
         end

         // ------------------------------------------------------------
         // BIST runs
         // ------------------------------------------------------------
         if (bist_start && !running) begin
            running <= 1'b1;
            run_cyc <= 0;
         end else if (running) begin
            if (bist_done) begin
               running <= 1'b0;
               runs_checked++;
               if (run_cyc != RUN_CYCLES) begin
                  log_failure(1'b0, $sformatf("bist_done after %0d cycles, expected %0d",
                                              run_cyc, RUN_CYCLES));
               end
               if (bist_fail != exp_fail) begin
                  log_failure(1'b0, $sformatf("bist_fail %0b, expected %0b",
                                              bist_fail, exp_fail));
               end
               if (exp_fail ? (fail_count == 8'd0) : (fail_count != 8'd0)) begin
                  log_failure(1'b0, $sformatf("fail_count %0d with expected fail %0b",
                                              fail_count, exp_fail));
               end
               if (first_fail_entry != exp_first) begin
                  log_failure(1'b0, $sformatf("first_fail_entry %0d, expected %0d",
                                              first_fail_entry, exp_first));
               end
               // Every entry rewritten by the last pass
               ref_valid <= '1;
               for (int i = 0; i < ENTRIES; i++) begin
                  ref_data[i] <= final_word();
               end
            end else begin
               run_cyc <= run_cyc + 1;
            end
         end
      end
   end

endmodule

//--- verif/tb_cam_bist.sv
/*
 * Testbench for the CAM self-test wrapper. Applies a table of functional and
 * BIST steps, including a stuck-at fault forced into one entry.
 */
`timescale 1ns/1ps

module tb_cam_bist
   import cam_bist_pkg::*;
();

   localparam int          DATA_WIDTH      = 8;
   localparam int          ENTRIES         = 8;
   localparam int          FAULT_ENTRY     = 3;
   localparam int          BIST_ROW_CYCLES = 4 * (ENTRIES + 1 + DATA_WIDTH) + 10;
   localparam logic [31:0] SEED            = 32'ha6978c69;

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_WRITE_RND,
      OP_COMPARE,
      OP_CMP_LAST,
      OP_START,
      OP_WAIT,
      OP_FORCE,
      OP_RELEASE
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic        exp_fail;
      logic [7:0]  exp_first;
   } row_t;

   // ------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------

   localparam int   NUM_ROWS = 34;
   localparam row_t ROWS [NUM_ROWS] = '{
      // Nothing written yet, so no hits
      '{OP_COMPARE,   8'd0, 32'h0000_0000, 1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_005A, 1'b0, 8'd0},
      // Random functional traffic, two entries share one word
      '{OP_WRITE_RND, 8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd1, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd2, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd3, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE,     8'd5, 32'h0000_003C, 1'b0, 8'd0},
      '{OP_WRITE,     8'd6, 32'h0000_003C, 1'b0, 8'd0},
      '{OP_CMP_LAST,  8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_CMP_LAST,  8'd3, 32'h0,         1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_003C, 1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd2, 32'h0,         1'b0, 8'd0},
      '{OP_CMP_LAST,  8'd2, 32'h0,         1'b0, 8'd0},
      '{OP_CMP_LAST,  8'd1, 32'h0,         1'b0, 8'd0},
      // Good array
      '{OP_START,     8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_WAIT,      8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_0055, 1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_0000, 1'b0, 8'd0},
      // Stuck-at one on bit 0 of the fault entry
      '{OP_FORCE,     8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_START,     8'd0, 32'h0,         1'b1, 8'(FAULT_ENTRY)},
      '{OP_WAIT,      8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_RELEASE,   8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_START,     8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_WAIT,      8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_0055, 1'b0, 8'd0},
      // Functional writes during a run must be dropped
      '{OP_START,     8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd1, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd4, 32'h0,         1'b0, 8'd0},
      '{OP_WRITE,     8'd7, 32'h0000_0000, 1'b0, 8'd0},
      '{OP_WAIT,      8'd0, 32'h0,         1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_0055, 1'b0, 8'd0},
      '{OP_COMPARE,   8'd0, 32'h0000_0000, 1'b0, 8'd0},
      '{OP_WRITE_RND, 8'd5, 32'h0,         1'b0, 8'd0},
      '{OP_CMP_LAST,  8'd5, 32'h0,         1'b0, 8'd0}
   };

   logic               bist_clk = 1'b0;
   logic               rst_b;
   logic               bist_start;
   cam_wr_req_t        func_wr;
   cam_cm_req_t        func_cm;
   logic               exp_fail;
   logic [7:0]         exp_first;
   logic [ENTRIES-1:0] hit;
   logic               hit_valid;
   logic               bist_done;
   logic               bist_fail;
   logic [7:0]         fail_count;
   logic [7:0]         first_fail_entry;
   int                 hit_checks;
   int                 hit_errors;
   int                 status_errors;
   int                 runs_checked;
   // Run bookkeeping
   int                 cycle_cnt = 0;
   int                 cycle_limit;
   int                 cur_row;
   int                 runs_started;
   logic [31:0]        lcg_state;
   logic [31:0]        last_wr [256];
   logic               pass_ok;

   always #4 bist_clk = ~bist_clk;

   cam_bist_top #(
      .DATA_WIDTH (DATA_WIDTH),
      .ENTRIES    (ENTRIES)
   ) UUT (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .bist_start       (bist_start),
      .func_wr          (func_wr),
      .func_cm          (func_cm),
      .hit              (hit),
      .hit_valid        (hit_valid),
      .bist_done        (bist_done),
      .bist_fail        (bist_fail),
      .fail_count       (fail_count),
      .first_fail_entry (first_fail_entry)
   );

   cam_bist_checker #(
      .DATA_WIDTH (DATA_WIDTH),
      .ENTRIES    (ENTRIES)
   ) u_chk (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .bist_start       (bist_start),
      .func_wr          (func_wr),
      .func_cm          (func_cm),
      .hit              (hit),
      .hit_valid        (hit_valid),
      .bist_done        (bist_done),
      .bist_fail        (bist_fail),
      .fail_count       (fail_count),
      .first_fail_entry (first_fail_entry),
      .exp_fail         (exp_fail),
      .exp_first        (exp_first),
      .hit_checks       (hit_checks),
      .hit_errors       (hit_errors),
      .status_errors    (status_errors),
      .runs_checked     (runs_checked)
   );

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // BIST rows get a full run plus slack, the rest a few cycles
   function automatic int cycle_budget();
      int sum;
      sum = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         sum += (ROWS[r].op == OP_START) ? BIST_ROW_CYCLES : 4;
      end
      return sum;
   endfunction

   // One table row per clock, inputs idle unless the row drives them
   task apply_row(input row_t row);
      logic [31:0] wdata;
      @(posedge bist_clk);
      bist_start <= 1'b0;
      func_wr    <= '0;
      func_cm    <= '0;
      case (row.op)
         OP_WRITE: begin
            func_wr <= '{en: 1'b1, addr: row.addr, data: row.data};
         end
         OP_WRITE_RND: begin
            lcg_state = lcg_step(lcg_state);
            // Upper half first, low LCG bits repeat quickly
            wdata = {lcg_state[15:0], lcg_state[31:16]};
            last_wr[row.addr] = wdata;
            func_wr <= '{en: 1'b1, addr: row.addr, data: wdata};
         end
         OP_COMPARE: begin
            func_cm <= '{en: 1'b1, data: row.data};
         end
         OP_CMP_LAST: begin
            func_cm <= '{en: 1'b1, data: last_wr[row.addr]};
         end
         OP_START: begin
            bist_start <= 1'b1;
            exp_fail   <= row.exp_fail;
            exp_first  <= row.exp_first;
            runs_started++;
         end
         OP_WAIT: begin
            // Sample away from the clock edge
            do begin
               @(negedge bist_clk);
            end while (!bist_done);
         end
         OP_FORCE: begin
            force UUT.u_cam.mem[FAULT_ENTRY][0] = 1'b1;
         end
         OP_RELEASE: begin
            release UUT.u_cam.mem[FAULT_ENTRY][0];
         end
         default: begin
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // Watchdog
   // ------------------------------------------------------------

   always @(posedge bist_clk) begin
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, run stuck in table row %0d", cycle_cnt, cur_row);
         $display("Verification failed");
         $finish;
      end else begin
         cycle_cnt <= cycle_cnt + 1;
      end
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------

   initial begin
      rst_b        = 1'b0;
      bist_start   = 1'b0;
      func_wr      = '0;
      func_cm      = '0;
      exp_fail     = 1'b0;
      exp_first    = 8'd0;
      lcg_state    = SEED;
      cur_row      = 0;
      runs_started = 0;
      cycle_limit  = cycle_budget();

      repeat (3) @(posedge bist_clk);
      rst_b <= 1'b1;

      for (int r = 0; r < NUM_ROWS; r++) begin
         cur_row = r;
         apply_row(ROWS[r]);
      end

      // Idle long enough for the last hit vector to be checked
      @(posedge bist_clk);
      func_wr <= '0;
      func_cm <= '0;
      repeat (3) @(posedge bist_clk);

      pass_ok = (hit_errors == 0) && (status_errors == 0) && (hit_checks > 0)
                && (runs_checked == runs_started);
      if (runs_checked != runs_started) begin
         $display("Only %0d of %0d BIST runs reached done", runs_checked, runs_started);
      end
      if (hit_checks == 0) begin
         $display("No functional hit vector was checked");
      end
      $display("Hit errors %0d, status errors %0d, over %0d hit checks and %0d BIST runs",
               hit_errors, status_errors, hit_checks, runs_checked);
      if (pass_ok) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- tb.f
design/cam_bist_pkg.sv
design/cam_bist_sequencer.sv
design/cam_bist_inhandler.sv
design/cam_array.sv
design/cam_bist_analyzer.sv
design/cam_bist_top.sv
verif/cam_bist_checker.sv
verif/tb_cam_bist.sv

//--- run_sim.sh
#!/bin/sh
# Build the CAM BIST testbench with Verilator, run it and scan the log
verilator --binary --assert -j 0 --top-module tb_cam_bist -f tb.f \
   -o sim_cam_bist > build.log 2>&1 \
   && ./obj_dir/sim_cam_bist > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log \
   && { echo "Result: FAIL"; exit 1; } \
   || { echo "Result: PASS"; exit 0; }
